//--- flist.f
rtl/xm_pkg.sv
rtl/bus_sync.sv
rtl/tick_timer.sv
rtl/access_ctrl.sv
rtl/reg_file.sv
rtl/xm_reg_top.sv
sim/tb_xm_reg_assert.sv
sim/tb_xm_reg.sv

//--- rtl/access_ctrl.sv
// ##########################################################################
// single outstanding memory access
// ##########################################################################

module access_ctrl
    import xm_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  mem_cmd_t  cmd_i,
    input  logic      cmd_valid_i,
    output logic      cmd_ready_o,
    output mem_req_t  vram_req_o,
    output logic      vram_valid_o,
    input  logic      vram_ready_i,
    input  word_t     vram_rdata_i,
    output mem_req_t  xr_req_o,
    output logic      xr_valid_o,
    input  logic      xr_ready_i,
    input  word_t     xr_rdata_i,
    output mem_done_t done_o,
    output logic      busy_o
);

    mem_target_e target_q;      // NONE when idle
    mem_kind_e   kind_q;
    mem_req_t    req_q;
    word_t       rdata_q;
    logic        done_q;
    logic        accept;
    logic        vram_fire, xr_fire;

    function automatic mem_target_e target_of(input mem_kind_e kind);
        case (kind)
            XR_READ, XR_WRITE: return XR;
            default:           return VRAM;
        endcase
    endfunction

    // the done cycle still counts as busy so the result lands first
    assign cmd_ready_o  = (target_q == NONE) && !done_q;
    assign busy_o       = !cmd_ready_o;
    assign accept       = cmd_valid_i && cmd_ready_o;

    assign vram_valid_o = (target_q == VRAM);
    assign xr_valid_o   = (target_q == XR);
    assign vram_fire    = vram_valid_o && vram_ready_i;
    assign xr_fire      = xr_valid_o && xr_ready_i;

    assign vram_req_o   = req_q;        // only the selected port is valid
    assign xr_req_o     = req_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            target_q <= NONE;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                target_q <= target_of(cmd_i.kind);
            end else if (vram_fire || xr_fire) begin
                target_q <= NONE;
                done_q   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            kind_q     <= cmd_i.kind;
            req_q.wr   <= (cmd_i.kind == VRAM_WRITE) || (cmd_i.kind == XR_WRITE);
            req_q.addr <= cmd_i.addr;
            req_q.data <= cmd_i.wdata;
            req_q.mask <= cmd_i.mask;
        end
        if (vram_fire || xr_fire) begin
            rdata_q <= vram_fire ? vram_rdata_i : xr_rdata_i;
        end
    end

    always_comb begin
        done_o.done  = done_q;
        done_o.kind  = kind_q;          // unchanged until next accept
        done_o.rdata = rdata_q;
    end

endmodule

//--- rtl/bus_sync.sv
// ##########################################################################
// host bus synchronizer
// ##########################################################################

module bus_sync
    import xm_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,
    input  logic       bus_rd_nwr_i,      // 1 = read
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  logic [7:0] bus_data_i,
    output bus_op_t    bus_op_o
);

    logic       cs_n_q1, cs_n_q2, cs_n_q3;
    logic       rd_nwr_q1, rd_nwr_q2;
    logic [3:0] reg_num_q1, reg_num_q2;
    logic       bytesel_q1, bytesel_q2;
    logic [7:0] data_q1, data_q2;
    logic       wr_strobe_q, rd_strobe_q;
    logic       cs_fall;

    assign cs_fall = cs_n_q3 && !cs_n_q2;   // select just went low

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_q1     <= 1'b1;
            cs_n_q2     <= 1'b1;
            cs_n_q3     <= 1'b1;
            wr_strobe_q <= 1'b0;
            rd_strobe_q <= 1'b0;
        end else begin
            cs_n_q1     <= bus_cs_n_i;
            cs_n_q2     <= cs_n_q1;
            cs_n_q3     <= cs_n_q2;             // edge detect stage
            wr_strobe_q <= cs_fall && !rd_nwr_q2;
            rd_strobe_q <= cs_fall && rd_nwr_q2;
        end
    end

    // payload stages, held stable by the host while selected
    always_ff @(posedge clk) begin
        rd_nwr_q1  <= bus_rd_nwr_i;
        rd_nwr_q2  <= rd_nwr_q1;
        reg_num_q1 <= bus_reg_num_i;
        reg_num_q2 <= reg_num_q1;
        bytesel_q1 <= bus_bytesel_i;
        bytesel_q2 <= bytesel_q1;
        data_q1    <= bus_data_i;
        data_q2    <= data_q1;
    end

    always_comb begin
        bus_op_o.wr_strobe = wr_strobe_q;
        bus_op_o.rd_strobe = rd_strobe_q;
        bus_op_o.reg_num   = xm_reg_e'(reg_num_q2);
        bus_op_o.bytesel   = bytesel_q2;
        bus_op_o.data      = data_q2;
    end

endmodule

//--- rtl/reg_file.sv
// ##########################################################################
// host register file
// ##########################################################################

module reg_file
    import xm_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  bus_op_t    bus_op_i,
    input  word_t      timer_i,
    input  logic       busy_i,            // memory access outstanding
    input  mem_done_t  done_i,
    output mem_cmd_t   cmd_o,
    output logic       cmd_valid_o,
    output logic [7:0] bus_data_o,
    output logic [3:0] intr_mask_o,
    output logic [3:0] intr_clear_o
);

    addr_t      reg_xr_addr;
    word_t      reg_xr_data;       // last XR read result
    word_t      reg_rd_incr;
    addr_t      reg_rd_addr;
    word_t      reg_rd_data;       // prefetched VRAM word
    word_t      reg_wr_incr;
    addr_t      reg_wr_addr;
    logic [7:0] reg_xr_data_even;  // pending high byte for XR_DATA
    logic [7:0] reg_data_even;     // pending high byte for DATA
    logic [3:0] reg_wr_mask;

    mem_cmd_t   cmd_next;
    logic       cmd_fire;
    logic       even_wr, odd_wr, odd_rd;

    assign even_wr = bus_op_i.wr_strobe && !bus_op_i.bytesel;
    assign odd_wr  = bus_op_i.wr_strobe && bus_op_i.bytesel;
    assign odd_rd  = bus_op_i.rd_strobe && bus_op_i.bytesel;

    function automatic logic [7:0] pick_byte(input word_t w, input logic odd);
        return odd ? w[7:0] : w[15:8];
    endfunction

    // read-back byte, valid while the host keeps select low
    always_comb begin
        case (bus_op_i.reg_num)
            XR_ADDR:
                bus_data_o = pick_byte(reg_xr_addr, bus_op_i.bytesel);
            XR_DATA:
                bus_data_o = pick_byte(reg_xr_data, bus_op_i.bytesel);
            RD_INCR:
                bus_data_o = pick_byte(reg_rd_incr, bus_op_i.bytesel);
            RD_ADDR:
                bus_data_o = pick_byte(reg_rd_addr, bus_op_i.bytesel);
            WR_INCR:
                bus_data_o = pick_byte(reg_wr_incr, bus_op_i.bytesel);
            WR_ADDR:
                bus_data_o = pick_byte(reg_wr_addr, bus_op_i.bytesel);
            DATA, DATA_2:
                bus_data_o = pick_byte(reg_rd_data, bus_op_i.bytesel);
            SYS_CTRL:
                bus_data_o = bus_op_i.bytesel ? {busy_i, 3'b000, reg_wr_mask}
                                              : {4'b0000, intr_mask_o};
            TIMER:
                bus_data_o = pick_byte(timer_i, bus_op_i.bytesel);
            default:
                bus_data_o = 8'h00;             // dropped slots
        endcase
    end

    // memory command decode, odd byte completes the word
    always_comb begin
        cmd_fire       = 1'b0;
        cmd_next.kind  = RD_PREFETCH;
        cmd_next.addr  = reg_rd_addr;
        cmd_next.wdata = {reg_data_even, bus_op_i.data};
        cmd_next.mask  = 4'hF;
        if (odd_wr) begin
            case (bus_op_i.reg_num)
                XR_ADDR: begin
                    cmd_fire      = 1'b1;
                    cmd_next.kind = XR_READ;
                    cmd_next.addr = {reg_xr_addr[15:8], bus_op_i.data};
                end
                XR_DATA: begin
                    cmd_fire       = 1'b1;
                    cmd_next.kind  = XR_WRITE;
                    cmd_next.addr  = reg_xr_addr;
                    cmd_next.wdata = {reg_xr_data_even, bus_op_i.data};
                end
                RD_ADDR: begin
                    cmd_fire      = 1'b1;
                    cmd_next.addr = {reg_rd_addr[15:8], bus_op_i.data};
                end
                DATA, DATA_2: begin
                    cmd_fire      = 1'b1;
                    cmd_next.kind = VRAM_WRITE;
                    cmd_next.addr = reg_wr_addr;
                    cmd_next.mask = reg_wr_mask;
                end
                default: ;
            endcase
        end else if (odd_rd && (bus_op_i.reg_num == DATA || bus_op_i.reg_num == DATA_2)) begin
            cmd_fire = 1'b1;                    // next prefetch at rd addr
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= cmd_fire;            // dropped downstream if busy
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            cmd_o <= cmd_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_xr_addr      <= '0;
            reg_xr_data      <= '0;
            reg_rd_incr      <= '0;
            reg_rd_addr      <= '0;
            reg_rd_data      <= '0;
            reg_wr_incr      <= '0;
            reg_wr_addr      <= '0;
            reg_xr_data_even <= '0;
            reg_data_even    <= '0;
            reg_wr_mask      <= 4'hF;
            intr_mask_o      <= 4'h0;
            intr_clear_o     <= 4'h0;
        end else begin
            intr_clear_o <= 4'h0;               // single cycle pulse

            if (done_i.done) begin
                case (done_i.kind)
                    RD_PREFETCH: begin
                        reg_rd_data <= done_i.rdata;
                        reg_rd_addr <= reg_rd_addr + reg_rd_incr;
                    end
                    VRAM_WRITE: reg_wr_addr <= reg_wr_addr + reg_wr_incr;
                    XR_READ:    reg_xr_data <= done_i.rdata;
                    XR_WRITE:   reg_xr_addr <= reg_xr_addr + 16'd1;
                    default: ;
                endcase
            end

            // bus writes win over a same-cycle completion
            if (even_wr) begin
                case (bus_op_i.reg_num)
                    XR_ADDR:      reg_xr_addr[15:8] <= bus_op_i.data;
                    XR_DATA:      reg_xr_data_even  <= bus_op_i.data;
                    RD_INCR:      reg_rd_incr[15:8] <= bus_op_i.data;
                    RD_ADDR:      reg_rd_addr[15:8] <= bus_op_i.data;
                    WR_INCR:      reg_wr_incr[15:8] <= bus_op_i.data;
                    WR_ADDR:      reg_wr_addr[15:8] <= bus_op_i.data;
                    DATA, DATA_2: reg_data_even     <= bus_op_i.data;
                    SYS_CTRL:     intr_mask_o       <= bus_op_i.data[3:0];
                    default: ;
                endcase
            end

            if (odd_wr) begin
                case (bus_op_i.reg_num)
                    XR_ADDR:  reg_xr_addr[7:0] <= bus_op_i.data;
                    RD_INCR:  reg_rd_incr[7:0] <= bus_op_i.data;
                    RD_ADDR:  reg_rd_addr[7:0] <= bus_op_i.data;
                    WR_INCR:  reg_wr_incr[7:0] <= bus_op_i.data;
                    WR_ADDR:  reg_wr_addr[7:0] <= bus_op_i.data;
                    SYS_CTRL: reg_wr_mask      <= bus_op_i.data[3:0];
                    TIMER:    intr_clear_o     <= bus_op_i.data[3:0];  // interrupt ack
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- rtl/tick_timer.sv
// ##########################################################################
// tenth millisecond timer
// ##########################################################################

module tick_timer
    import xm_pkg::*;
#(
    parameter int CLKS_PER_TICK = 2512
) (
    input  logic  clk,
    input  logic  reset_i,
    output word_t timer_o
);

    localparam int FRAC_W = $clog2(CLKS_PER_TICK + 1);

    logic [FRAC_W-1:0] frac_q;      // clocks within current tick

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac_q  <= '0;
            timer_o <= '0;
        end else if (frac_q == FRAC_W'(CLKS_PER_TICK - 1)) begin
            frac_q  <= '0;
            timer_o <= timer_o + 16'd1;  // wraps at 16 bits
        end else begin
            frac_q <= frac_q + 1'b1;
        end
    end

endmodule

//--- rtl/xm_pkg.sv
// ##########################################################################
// host register block shared types
// ##########################################################################

package xm_pkg;

    // clocks per 0.1 ms at 25.125 MHz
    localparam int TICKS_DEFAULT = 2512;

    typedef logic [15:0] word_t;    // register and memory word
    typedef logic [15:0] addr_t;    // VRAM or XR address

    // host register numbers, even byte is the high byte
    typedef enum logic [3:0] {
        XR_ADDR   = 4'h0,
        XR_DATA   = 4'h1,
        RD_INCR   = 4'h2,
        RD_ADDR   = 4'h3,
        WR_INCR   = 4'h4,
        WR_ADDR   = 4'h5,
        DATA      = 4'h6,
        DATA_2    = 4'h7,
        SYS_CTRL  = 4'h8,
        TIMER     = 4'h9,
        UNUSED_A  = 4'hA,
        UNUSED_B  = 4'hB,
        RW_INCR   = 4'hC,
        RW_ADDR   = 4'hD,
        RW_DATA   = 4'hE,
        RW_DATA_2 = 4'hF
    } xm_reg_e;

    typedef struct packed {
        logic       wr_strobe;      // one cycle per chip select
        logic       rd_strobe;
        xm_reg_e    reg_num;
        logic       bytesel;        // 1 = odd byte
        logic [7:0] data;
    } bus_op_t;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        VRAM = 2'd1,
        XR   = 2'd2
    } mem_target_e;

    typedef enum logic [1:0] {
        RD_PREFETCH = 2'd0,
        XR_READ     = 2'd1,
        VRAM_WRITE  = 2'd2,
        XR_WRITE    = 2'd3
    } mem_kind_e;

    typedef struct packed {
        mem_kind_e  kind;
        addr_t      addr;
        word_t      wdata;
        logic [3:0] mask;           // nibble write enables
    } mem_cmd_t;

    typedef struct packed {
        logic       wr;
        addr_t      addr;
        word_t      data;
        logic [3:0] mask;
    } mem_req_t;

    typedef struct packed {
        logic       done;
        mem_kind_e  kind;
        word_t      rdata;
    } mem_done_t;

endpackage

//--- rtl/xm_reg_top.sv
// ##########################################################################
// host register block top level
// ##########################################################################

module xm_reg_top
    import xm_pkg::*;
#(
    parameter int CLKS_PER_TICK = TICKS_DEFAULT
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,
    input  logic       bus_rd_nwr_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o,
    output mem_req_t   vram_req_o,
    output logic       vram_valid_o,
    input  logic       vram_ready_i,
    input  word_t      vram_rdata_i,
    output mem_req_t   xr_req_o,
    output logic       xr_valid_o,
    input  logic       xr_ready_i,
    input  word_t      xr_rdata_i,
    output logic [3:0] intr_mask_o,
    output logic [3:0] intr_clear_o
);

    bus_op_t   bus_op;
    word_t     timer;
    logic      busy;
    mem_done_t done;
    mem_cmd_t  cmd;
    logic      cmd_valid;

    bus_sync i_bus_sync (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_op_o      (bus_op)
    );

    tick_timer #(
        .CLKS_PER_TICK (CLKS_PER_TICK)
    ) i_tick_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .timer_o (timer)
    );

    access_ctrl i_access_ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_i        (cmd),
        .cmd_valid_i  (cmd_valid),
        .cmd_ready_o  (),               // reg_file never holds a command
        .vram_req_o   (vram_req_o),
        .vram_valid_o (vram_valid_o),
        .vram_ready_i (vram_ready_i),
        .vram_rdata_i (vram_rdata_i),
        .xr_req_o     (xr_req_o),
        .xr_valid_o   (xr_valid_o),
        .xr_ready_i   (xr_ready_i),
        .xr_rdata_i   (xr_rdata_i),
        .done_o       (done),
        .busy_o       (busy)
    );

    reg_file i_reg_file (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_op_i     (bus_op),
        .timer_i      (timer),
        .busy_i       (busy),
        .done_i       (done),
        .cmd_o        (cmd),
        .cmd_valid_o  (cmd_valid),
        .bus_data_o   (bus_data_o),
        .intr_mask_o  (intr_mask_o),
        .intr_clear_o (intr_clear_o)
    );

endmodule

//--- sim/tb_xm_reg.sv
// ##########################################################################
// host register block testbench
// ##########################################################################

module tb_xm_reg
    import xm_pkg::*;
;

    localparam int TICKS           = 20;
    localparam int MAX_CASES       = 64;
    localparam int CYCLES_PER_CASE = 200;

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    logic [3:0] bus_reg_num_i;
    logic [7:0] bus_data_i, bus_data_o;
    mem_req_t   vram_req_o, xr_req_o;
    logic       vram_valid_o, vram_ready_i, xr_valid_o, xr_ready_i;
    word_t      vram_rdata_i, xr_rdata_i;
    logic [3:0] intr_mask_o, intr_clear_o;

    word_t       vram_mem [0:65535];
    word_t       xr_mem [0:65535];
    logic [35:0] cases [0:MAX_CASES-1];     // op, arg1, arg2
    int          n_cases = 0;
    int          errors = 0;
    int          clear_seen = 0;            // intr_clear_o pulses so far
    logic [3:0]  clear_last = 4'h0;         // nibble of the latest pulse

    xm_reg_top #(
        .CLKS_PER_TICK (TICKS)
    ) i_xm_reg_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (intr_clear_o != 4'h0) begin
            clear_seen = clear_seen + 1;
            clear_last = intr_clear_o;
        end
    end

    function automatic word_t merge_nibbles(input word_t old, input word_t wd,
                                            input logic [3:0] mask);
        word_t res;
        res = old;
        for (int n = 0; n < 4; n++) begin
            if (mask[n]) res[4*n +: 4] = wd[4*n +: 4];
        end
        return res;
    endfunction

    // one chip select cycle: 6 clocks low, 2 high
    task automatic bus_cycle(input logic rd, input logic [3:0] num, input logic odd,
                             input logic [7:0] wd, output logic [7:0] rd_byte);
        @(negedge clk);
        bus_rd_nwr_i  = rd;
        bus_reg_num_i = num;
        bus_bytesel_i = odd;
        bus_data_i    = wd;
        bus_cs_n_i    = 1'b0;
        repeat (5) @(negedge clk);
        rd_byte = bus_data_o;               // last low cycle
        @(negedge clk);
        bus_cs_n_i = 1'b1;
        @(negedge clk);
    endtask

    task automatic write_word(input logic [3:0] num, input word_t w);
        logic [7:0] unused;
        bus_cycle(1'b0, num, 1'b0, w[15:8], unused);
        bus_cycle(1'b0, num, 1'b1, w[7:0], unused);
    endtask

    task automatic read_word(input logic [3:0] num, output word_t w);
        bus_cycle(1'b1, num, 1'b0, 8'h00, w[15:8]);
        bus_cycle(1'b1, num, 1'b1, 8'h00, w[7:0]);
    endtask

    task automatic wait_idle();
        logic [7:0] status;
        status = 8'h80;
        while (status[7]) bus_cycle(1'b1, SYS_CTRL, 1'b1, 8'h00, status);
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // answers whichever port is valid after a random delay
    initial begin : mem_model
        int unsigned d;
        vram_ready_i = 1'b0;
        xr_ready_i   = 1'b0;
        vram_rdata_i = '0;
        xr_rdata_i   = '0;
        void'($urandom(51));
        forever begin
            @(negedge clk);
            if (vram_valid_o || xr_valid_o) begin
                d = $urandom_range(5, 0);
                repeat (d) @(negedge clk);
                if (vram_valid_o) begin
                    vram_rdata_i = vram_mem[vram_req_o.addr];
                    if (vram_req_o.wr) begin
                        vram_mem[vram_req_o.addr] = merge_nibbles(vram_mem[vram_req_o.addr],
                                                                  vram_req_o.data,
                                                                  vram_req_o.mask);
                    end
                    vram_ready_i = 1'b1;
                end else begin
                    xr_rdata_i = xr_mem[xr_req_o.addr];
                    if (xr_req_o.wr) xr_mem[xr_req_o.addr] = xr_req_o.data;
                    xr_ready_i = 1'b1;
                end
                @(negedge clk);
                vram_ready_i = 1'b0;
                xr_ready_i   = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (n_cases > 0);
        repeat (n_cases * CYCLES_PER_CASE + 10) @(posedge clk);
        $display("Timeout: the case list did not finish within %0d cycles",
                 n_cases * CYCLES_PER_CASE);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : run
        logic [3:0] op;
        word_t      a1, a2, got, t0, t1, rd_run, rd_step;
        int         tests, errs_before, pulses, lo, hi, delta;
        bit         checked;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b0;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        reset_i       = 1'b1;
        tests         = 0;
        rd_run        = '0;
        rd_step       = '0;
        for (int a = 0; a < 65536; a++) begin
            vram_mem[a] = 16'(a) ^ 16'hC35A;            // whole-address fill
            xr_mem[a]   = 16'(a * 7) ^ 16'h3C96;
        end
        for (int i = 0; i < MAX_CASES; i++) cases[i] = '0;
        $readmemh("sim/xm_reg_cases.txt", cases);
        while (n_cases < MAX_CASES && cases[n_cases][35:32] != 4'h0) n_cases++;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        if (n_cases == 0) begin
            $display("No cases could be loaded from sim/xm_reg_cases.txt");
            errors++;
        end

        for (int i = 0; i < n_cases; i++) begin
            op          = cases[i][35:32];
            a1          = cases[i][31:16];
            a2          = cases[i][15:0];
            errs_before = errors;
            checked     = 1'b1;
            case (op)
                4'h1: begin
                    wait_idle();
                    write_word(a1[3:0], a2);
                    if (a1[3:0] == RD_ADDR) rd_run = a2;  // tb's own prefetch address
                    if (a1[3:0] == RD_INCR) rd_step = a2;
                    checked = 1'b0;
                end
                4'h2: begin
                    wait_idle();
                    read_word(a1[3:0], got);
                    check_word($sformatf("register %h", a1[3:0]), got, a2);
                end
                4'h3: begin
                    vram_mem[a1] = a2;
                    checked      = 1'b0;
                end
                4'h4: begin
                    xr_mem[a1] = a2;
                    checked    = 1'b0;
                end
                4'h5: begin
                    wait_idle();
                    check_word($sformatf("VRAM[%h]", a1), vram_mem[a1], a2);
                end
                4'h6: begin
                    wait_idle();
                    check_word($sformatf("XR[%h]", a1), xr_mem[a1], a2);
                end
                4'h7: begin
                    wait_idle();
                    read_word(DATA, got);
                    check_word($sformatf("DATA at %h", rd_run), got, vram_mem[rd_run]);
                    rd_run = rd_run + rd_step;
                end
                4'h8: check_word("intr_mask_o", {12'h000, intr_mask_o}, a2);
                4'h9: begin
                    pulses = clear_seen;
                    write_word(TIMER, {12'h000, a2[3:0]});
                    repeat (4) @(negedge clk);
                    pulses = clear_seen - pulses;
                    assert (pulses == 1) else begin
                        $display("Error at %0t: %0d intr_clear_o pulses, expected 1",
                                 $time, pulses);
                        errors++;
                    end
                    check_word("intr_clear_o", {12'h000, clear_last}, {12'h000, a2[3:0]});
                end
                4'hA: begin
                    read_word(TIMER, t0);
                    repeat (a2) @(negedge clk);
                    read_word(TIMER, t1);
                    delta = int'(word_t'(t1 - t0));
                    lo    = int'(a2) / TICKS - 1;
                    hi    = (int'(a2) + TICKS - 1) / TICKS + 1;
                    assert (delta >= lo && delta <= hi) else begin
                        $display("Error at %0t: timer moved %0d in %0d cycles, expected %0d..%0d",
                                 $time, delta, a2, lo, hi);
                        errors++;
                    end
                end
                4'hB: begin
                    repeat (a2) @(negedge clk);
                    checked = 1'b0;
                end
                default: begin
                    $display("Case line %0d holds an unknown operation %h", i, op);
                    errors++;
                end
            endcase
            if (checked) begin
                tests++;
                $display("test %0d (op %h, %h): %s", tests, op, a1,
                         (errors == errs_before) ? "ok" : "mismatch");
            end
        end

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0 && tests > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/tb_xm_reg_assert.sv
// ##########################################################################
// memory handshake assertions
// ##########################################################################

module tb_xm_reg_assert
    import xm_pkg::*;
(
    input logic     clk,
    input logic     reset_i,
    input mem_req_t vram_req_i,
    input logic     vram_valid_i,
    input logic     vram_ready_i,
    input mem_req_t xr_req_i,
    input logic     xr_valid_i,
    input logic     xr_ready_i
);

    vram_hold: assert property (@(posedge clk) disable iff (reset_i)
        vram_valid_i && !vram_ready_i |=> vram_valid_i && $stable(vram_req_i))
        else $error("VRAM request changed before ready");

    xr_hold: assert property (@(posedge clk) disable iff (reset_i)
        xr_valid_i && !xr_ready_i |=> xr_valid_i && $stable(xr_req_i))
        else $error("XR request changed before ready");

    one_port: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_valid_i && xr_valid_i))
        else $error("VRAM and XR requests raised together");

    idle_after_reset: assert property (@(posedge clk)
        reset_i |=> !vram_valid_i && !xr_valid_i)
        else $error("memory request raised right after reset");

endmodule

bind access_ctrl tb_xm_reg_assert i_access_assert (
    .clk          (clk),
    .reset_i      (reset_i),
    .vram_req_i   (vram_req_o),
    .vram_valid_i (vram_valid_o),
    .vram_ready_i (vram_ready_i),
    .xr_req_i     (xr_req_o),
    .xr_valid_i   (xr_valid_o),
    .xr_ready_i   (xr_ready_i)
);

//--- sim/xm_reg_cases.txt
// columns op_arg1_arg2 in hex; op 1 write reg,word 2 read reg,expect 3/4 preload VRAM/XR addr,word
// 5/6 check VRAM/XR addr,word 7 DATA read 8 intr mask 9 intr clear nibble A timer cycles B wait
1_0002_0001  // RD_INCR
1_0004_0003  // WR_INCR
2_0002_0001
2_0004_0003
1_0000_0120  // XR_ADDR, also starts an XR read
2_0000_0120
2_000A_0000  // dropped slots read zero
2_000D_0000
2_000F_0000
3_0200_1234
3_0201_5678
3_0202_9ABC
1_0003_0200  // RD_ADDR starts the prefetch
7_0000_0000
7_0000_0000
7_0000_0000
2_0003_0204
3_0300_AAAA
1_0005_0300  // WR_ADDR
1_0008_0306  // intr mask 3, write mask 0110
2_0008_0306
8_0000_0003
1_0006_1234
5_0300_A23A
2_0005_0303
1_0008_000F
1_0007_5678  // DATA_2 with full mask
5_0303_5678
4_0040_BEEF
1_0000_0040
2_0001_BEEF
1_0001_C0DE
6_0040_C0DE
2_0000_0041
9_0000_0005
A_0000_0064
A_0000_00C8
B_0000_0010
